// ==== verilog/alu_pkg.sv ====
// ========================================
// alu_pkg: operand, flag, opcode and
// request/response types of the integer ALU
// ========================================
`default_nettype none

package alu_pkg;

  typedef logic [63:0] word_t;
  typedef logic [3:0]  cond_t;

  typedef struct packed {
    logic c; // carry, or borrow after sub
    logic o;
    logic a; // carry/borrow out of bit 3
    logic s;
    logic z;
    logic p; // even parity of low byte
  } flags_t;

  // condition codes
  localparam cond_t cc_z   = 4'd0;
  localparam cond_t cc_nz  = 4'd1;
  localparam cond_t cc_s   = 4'd2;
  localparam cond_t cc_ns  = 4'd3;
  localparam cond_t cc_ugt = 4'd4;
  localparam cond_t cc_ule = 4'd5;
  localparam cond_t cc_uge = 4'd6;
  localparam cond_t cc_ult = 4'd7;
  localparam cond_t cc_sgt = 4'd8;
  localparam cond_t cc_sle = 4'd9;
  localparam cond_t cc_sge = 4'd10;
  localparam cond_t cc_slt = 4'd11;
  localparam cond_t cc_o   = 4'd12;
  localparam cond_t cc_no  = 4'd13;
  localparam cond_t cc_p   = 4'd14;
  localparam cond_t cc_np  = 4'd15;

  typedef enum logic [4:0] {
    op_add   = 5'd0,
    op_sub   = 5'd1,
    op_and   = 5'd2,
    op_or    = 5'd3,
    op_xor   = 5'd4,
    op_xnor  = 5'd5,
    op_mov   = 5'd6,
    op_zxt8  = 5'd7,
    op_zxt16 = 5'd8,
    op_sxt8  = 5'd9,
    op_sxt16 = 5'd10,
    op_sxt32 = 5'd11,
    op_cmov  = 5'd12,
    op_cset  = 5'd13
  } alu_op_e;

  typedef struct packed {
    logic    valid;
    alu_op_e op;
    logic    is32;      // upper half of result forced to zero
    logic    set_flags;
    cond_t   cond;
    logic    thread;
    word_t   a;
    word_t   b;
    flags_t  flags_in;  // current architectural flags
  } alu_req_t;

  typedef struct packed {
    word_t  result;
    flags_t flags;
  } unit_out_t;

  typedef struct packed {
    logic   valid;
    logic   thread;
    word_t  result;
    flags_t flags;
    logic   flags_we;
  } alu_resp_t;

  // sign, zero and parity of a result, other flags clear
  function automatic flags_t szp_flags(input word_t res, input logic is32);
    flags_t f;
    f   = '0;
    f.s = is32 ? res[31] : res[63];
    f.z = (res == 64'b0); // upper half already zero for 32-bit ops
    f.p = ~^res[7:0];
    return f;
  endfunction

endpackage

`default_nettype wire

// ==== verilog/cond_eval.sv ====
// ========================================
// cond_eval: decides a 4-bit condition
// code against a flag word
// ========================================
`timescale 1ns/1ps
`default_nettype none

module cond_eval (
  input  alu_pkg::flags_t flags,
  input  alu_pkg::cond_t  cond,
  output logic            taken
);
  import alu_pkg::*;

  // c holds the borrow after a compare
  always_comb begin
    case (cond)
      cc_z:    taken = flags.z;
      cc_nz:   taken = !flags.z;
      cc_s:    taken = flags.s;
      cc_ns:   taken = !flags.s;
      cc_ugt:  taken = !flags.c && !flags.z;
      cc_ule:  taken = flags.c || flags.z;
      cc_uge:  taken = !flags.c;
      cc_ult:  taken = flags.c;
      cc_sgt:  taken = (flags.s == flags.o) && !flags.z;
      cc_sle:  taken = (flags.s != flags.o) || flags.z;
      cc_sge:  taken = (flags.s == flags.o);
      cc_slt:  taken = (flags.s != flags.o);
      cc_o:    taken = flags.o;
      cc_no:   taken = !flags.o;
      cc_p:    taken = flags.p;
      default: taken = !flags.p; // np
    endcase
  end

endmodule

`default_nettype wire

// ==== verilog/arith_unit.sv ====
// ========================================
// arith_unit: 64/32-bit add and subtract
// with carry, overflow and nibble flags
// ========================================
`timescale 1ns/1ps
`default_nettype none

module arith_unit (
  input  alu_pkg::alu_req_t  req,
  output alu_pkg::unit_out_t out
);
  import alu_pkg::*;

  logic        sub;
  word_t       b_op;
  logic [64:0] sum;
  logic        carry32;
  logic        carry4;
  logic        cout;
  logic        sign_a;
  logic        sign_b;
  logic        sign_r;
  word_t       res;
  flags_t      flags;

  assign sub  = (req.op == op_sub);
  assign b_op = sub ? ~req.b : req.b; // a - b as a + ~b + 1

  assign sum = {1'b0, req.a} + {1'b0, b_op} + 65'(sub);

  // carries out of bit 31 and bit 3, recovered from the sum bits above them
  assign carry32 = req.a[32] ^ b_op[32] ^ sum[32];
  assign carry4  = req.a[4] ^ b_op[4] ^ sum[4];

  assign res  = req.is32 ? {32'b0, sum[31:0]} : sum[63:0];
  assign cout = req.is32 ? carry32 : sum[64];

  // operand signs after inversion, so one overflow rule covers add and sub
  assign sign_a = req.is32 ? req.a[31] : req.a[63];
  assign sign_b = req.is32 ? b_op[31] : b_op[63];
  assign sign_r = req.is32 ? sum[31] : sum[63];

  always_comb begin
    flags   = szp_flags(res, req.is32);
    flags.c = cout ^ sub;   // borrow is the missing carry
    flags.o = (sign_a == sign_b) && (sign_r != sign_a);
    flags.a = carry4 ^ sub;
  end

  assign out = '{result: res, flags: flags};

endmodule

`default_nettype wire

// ==== verilog/logic_move_unit.sv ====
// ========================================
// logic_move_unit: bitwise, move, extend,
// cmov and cset with logical flags
// ========================================
`timescale 1ns/1ps
`default_nettype none

module logic_move_unit (
  input  alu_pkg::alu_req_t  req,
  output alu_pkg::unit_out_t out
);
  import alu_pkg::*;

  logic  taken;
  word_t raw;
  word_t res;

  cond_eval cond_eval_i (
    .flags (req.flags_in),
    .cond  (req.cond),
    .taken (taken)
  );

  always_comb begin
    case (req.op)
      op_and:   raw = req.a & req.b;
      op_or:    raw = req.a | req.b;
      op_xor:   raw = req.a ^ req.b;
      op_xnor:  raw = ~(req.a ^ req.b);
      op_mov:   raw = req.b;
      op_zxt8:  raw = {56'b0, req.b[7:0]};
      op_zxt16: raw = {48'b0, req.b[15:0]};
      op_sxt8:  raw = {{56{req.b[7]}}, req.b[7:0]};
      op_sxt16: raw = {{48{req.b[15]}}, req.b[15:0]};
      op_sxt32: raw = {{32{req.b[31]}}, req.b[31:0]};
      op_cmov:  raw = taken ? req.b : req.a;
      op_cset:  raw = {63'b0, taken};
      default:  raw = '0; // add/sub come from arith_unit
    endcase
  end

  // 32-bit forms clear the upper half
  assign res = req.is32 ? {32'b0, raw[31:0]} : raw;

  assign out = '{result: res, flags: szp_flags(res, req.is32)};

endmodule

`default_nettype wire

// ==== verilog/writeback_stage.sv ====
// ========================================
// writeback_stage: result select, output
// register and per-thread flush filter
// ========================================
`timescale 1ns/1ps
`default_nettype none

module writeback_stage (
  input  logic                clk,
  input  logic                rst,
  input  alu_pkg::alu_req_t   req,
  input  alu_pkg::unit_out_t  arith_out,
  input  alu_pkg::unit_out_t  logic_out,
  input  logic                flush,
  input  logic                flush_thread,
  output alu_pkg::alu_resp_t  resp
);
  import alu_pkg::*;

  logic      is_arith;
  logic      is_bitwise;
  logic      flags_we_d;
  logic      kill;
  unit_out_t sel;

  logic      flush_q;
  logic      flush_thread_q;
  logic      valid_q;
  logic      flags_we_q;
  logic      thread_q;
  unit_out_t sel_q;

  assign is_arith   = (req.op == op_add) || (req.op == op_sub);
  assign is_bitwise = (req.op == op_and) || (req.op == op_or) ||
                      (req.op == op_xor) || (req.op == op_xnor);

  assign sel        = is_arith ? arith_out : logic_out;
  assign flags_we_d = req.set_flags && (is_arith || is_bitwise);

  // flush kills its thread now and one cycle on
  assign kill = (flush && (flush_thread == req.thread)) ||
                (flush_q && (flush_thread_q == req.thread));

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q        <= 1'b0;
      flags_we_q     <= 1'b0;
      flush_q        <= 1'b0;
      flush_thread_q <= 1'b0;
    end else begin
      valid_q        <= req.valid && !kill;
      flags_we_q     <= flags_we_d;
      flush_q        <= flush;
      flush_thread_q <= flush_thread;
    end
  end

  always_ff @(posedge clk) begin
    thread_q <= req.thread;
    sel_q    <= sel;
  end

  assign resp = '{valid:    valid_q,
                  thread:   thread_q,
                  result:   sel_q.result,
                  flags:    sel_q.flags,
                  flags_we: flags_we_q};

endmodule

`default_nettype wire

// ==== verilog/int_alu.sv ====
// ========================================
// int_alu: single-stage integer ALU for a
// two-thread core, 1 cycle latency
// ========================================
`timescale 1ns/1ps
`default_nettype none

module int_alu (
  input  logic               clk,
  input  logic               rst,
  input  alu_pkg::alu_req_t  req,
  input  logic               flush,
  input  logic               flush_thread,
  output alu_pkg::alu_resp_t resp
);
  import alu_pkg::*;

  unit_out_t arith_out;
  unit_out_t logic_out;

  arith_unit arith_unit_i (
    .req (req),
    .out (arith_out)
  );

  logic_move_unit logic_move_unit_i (
    .req (req),
    .out (logic_out)
  );

  writeback_stage writeback_stage_i (
    .clk          (clk),
    .rst          (rst),
    .req          (req),
    .arith_out    (arith_out),
    .logic_out    (logic_out),
    .flush        (flush),
    .flush_thread (flush_thread),
    .resp         (resp)
  );

endmodule

`default_nettype wire

// ==== tb/int_alu_tb.sv ====
// ========================================
// int_alu_tb: random and directed tests of
// the integer ALU against a reference model
// ========================================
`timescale 1ns/1ps
`default_nettype none

module int_alu_tb;
  import alu_pkg::*;

  logic      clk = 1'b0;
  logic      rst;
  alu_req_t  req;
  logic      flush;
  logic      flush_thread;
  alu_resp_t resp;

  integer    seed = 32'ha70c_6201;
  int        cycle = 0;
  int        errors = 0;           // current test only
  int        tests_passed = 0;
  int        tests_failed = 0;
  string     test_name = "reset";
  logic      flush_q = 1'b0;       // flush of the previous drive
  logic      flush_thread_q = 1'b0;
  alu_resp_t exp_q[$];
  int        stamp_q[$];           // drive cycle of each expected entry

  int_alu int_alu_i (
    .clk          (clk),
    .rst          (rst),
    .req          (req),
    .flush        (flush),
    .flush_thread (flush_thread),
    .resp         (resp)
  );

  always #2 clk = ~clk;
  always @(posedge clk) cycle <= cycle + 1;

  function automatic int rand_below(input int n);
    return $unsigned($random(seed)) % n;
  endfunction

  // corner values at both widths, upper half random for the 32-bit ones
  function automatic word_t pick_operand();
    case (rand_below(10))
      0:       return '0;
      1:       return '1;
      2:       return 64'h7fff_ffff_ffff_ffff;
      3:       return 64'h8000_0000_0000_0000;
      4:       return {$random(seed), 32'h7fff_ffff};
      5:       return {$random(seed), 32'h8000_0000};
      6:       return {$random(seed), 32'hffff_ffff};
      7:       return 64'd1;
      default: return {$random(seed), $random(seed)};
    endcase
  endfunction

  // odd codes are the inverse of the even code below them
  function automatic logic cond_holds(input flags_t f, input cond_t c);
    logic lt;
    logic hit;
    lt = f.s ^ f.o;
    case (c[3:1])
      3'd0:    hit = f.z;
      3'd1:    hit = f.s;
      3'd2:    hit = !f.c && !f.z; // ugt
      3'd3:    hit = !f.c;         // uge
      3'd4:    hit = !lt && !f.z;  // sgt
      3'd5:    hit = !lt;          // sge
      3'd6:    hit = f.o;
      default: hit = f.p;
    endcase
    return hit ^ c[0];
  endfunction

  function automatic alu_resp_t ref_model(input alu_req_t r);
    alu_resp_t   e;
    word_t       a_m;
    word_t       b_m;
    word_t       res;
    logic [64:0] wide;
    logic        msb_a;
    logic        msb_b;
    logic        msb_r;
    logic        taken;
    e        = '0;
    e.valid  = r.valid;
    e.thread = r.thread;
    a_m      = r.is32 ? {32'b0, r.a[31:0]} : r.a;
    b_m      = r.is32 ? {32'b0, r.b[31:0]} : r.b;
    taken    = cond_holds(r.flags_in, r.cond);
    case (r.op)
      op_add:   res = a_m + b_m;
      op_sub:   res = a_m - b_m;
      op_and:   res = r.a & r.b;
      op_or:    res = r.a | r.b;
      op_xor:   res = r.a ^ r.b;
      op_xnor:  res = ~(r.a ^ r.b);
      op_mov:   res = r.b;
      op_zxt8:  res = 64'(r.b[7:0]);
      op_zxt16: res = 64'(r.b[15:0]);
      op_sxt8:  res = 64'($signed(r.b[7:0]));
      op_sxt16: res = 64'($signed(r.b[15:0]));
      op_sxt32: res = 64'($signed(r.b[31:0]));
      op_cmov:  res = taken ? r.b : r.a;
      op_cset:  res = taken ? 64'd1 : 64'd0;
      default:  res = '0;
    endcase
    if (r.is32)
      res[63:32] = '0;
    msb_a     = r.is32 ? r.a[31] : r.a[63];
    msb_b     = r.is32 ? r.b[31] : r.b[63];
    msb_r     = r.is32 ? res[31] : res[63];
    e.result  = res;
    e.flags.s = msb_r;
    e.flags.z = (res == 64'd0);
    e.flags.p = ~^res[7:0];
    if (r.op == op_add) begin
      wide       = {1'b0, a_m} + {1'b0, b_m};
      e.flags.c  = r.is32 ? wide[32] : wide[64];
      e.flags.o  = (msb_a == msb_b) && (msb_r != msb_a);
      e.flags.a  = (5'(r.a[3:0]) + 5'(r.b[3:0])) > 5'd15;
      e.flags_we = r.set_flags;
    end else if (r.op == op_sub) begin
      e.flags.c  = a_m < b_m;
      e.flags.o  = (msb_a != msb_b) && (msb_r != msb_a);
      e.flags.a  = r.a[3:0] < r.b[3:0];
      e.flags_we = r.set_flags;
    end else begin
      e.flags_we = r.set_flags && (r.op inside {op_and, op_or, op_xor, op_xnor});
    end
    return e;
  endfunction

  function automatic alu_req_t build_req(input alu_op_e op, input cond_t c);
    alu_req_t r;
    r.valid     = 1'b1;
    r.op        = op;
    r.is32      = 1'(rand_below(2));
    r.set_flags = 1'(rand_below(2));
    r.cond      = c;
    r.thread    = 1'(rand_below(2));
    r.a         = {$random(seed), $random(seed)};
    r.b         = {$random(seed), $random(seed)};
    r.flags_in  = flags_t'(6'(rand_below(64)));
    return r;
  endfunction

  task automatic send(input alu_req_t r, input logic fl, input logic ft);
    alu_resp_t e;
    @(negedge clk);
    req          = r;
    flush        = fl;
    flush_thread = ft;
    e            = ref_model(r);
    // flush kills its thread at this edge and the next
    if ((fl && ft == r.thread) || (flush_q && flush_thread_q == r.thread))
      e.valid = 1'b0;
    flush_q        = fl;
    flush_thread_q = ft;
    exp_q.push_back(e);
    stamp_q.push_back(cycle);
  endtask

  task automatic report_mismatch(input string field, input logic [63:0] exp_v,
                                 input logic [63:0] act_v);
    $display("Error %s %s: expected %h, actual %h", test_name, field, exp_v, act_v);
    errors++;
  endtask

  // response of a drive shows up one negedge later
  always @(negedge clk) begin
    alu_resp_t e;
    if (stamp_q.size() > 0 && stamp_q[0] == cycle - 1) begin
      e = exp_q[0];
      if (resp.valid !== e.valid)
        report_mismatch("valid", 64'(e.valid), 64'(resp.valid));
      if (resp.flags_we !== e.flags_we)
        report_mismatch("flags_we", 64'(e.flags_we), 64'(resp.flags_we));
      if (e.valid && resp.thread !== e.thread)
        report_mismatch("thread", 64'(e.thread), 64'(resp.thread));
      if (e.valid && resp.result !== e.result)
        report_mismatch("result", e.result, resp.result);
      if (e.valid && resp.flags !== e.flags)
        report_mismatch("flags", 64'(e.flags), 64'(resp.flags));
      void'(exp_q.pop_front());
      void'(stamp_q.pop_front());
    end
  end

  task automatic end_test();
    int waited;
    waited = 0;
    send('0, 1'b0, 1'b0);
    while (exp_q.size() > 0 && waited < 10) begin
      @(negedge clk);
      waited++;
    end
    if (exp_q.size() > 0) begin
      $display("%s: timed out with %0d responses still pending", test_name, exp_q.size());
      errors++;
    end
    if (errors == 0) begin
      tests_passed++;
      $display("test %s passed", test_name);
    end else begin
      tests_failed++;
      $display("test %s failed with %0d errors", test_name, errors);
    end
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    errors    = 0;
  endtask

  initial begin
    alu_req_t r;
    rst           = 1'b1;
    req           = '0;
    req.valid     = 1'b1;  // must not leak through reset
    req.set_flags = 1'b1;
    flush         = 1'b0;
    flush_thread  = 1'b0;
    begin_test("reset");
    repeat (8) begin
      @(negedge clk);
      if (resp.valid !== 1'b0)
        report_mismatch("valid", 64'd0, 64'(resp.valid));
      if (resp.flags_we !== 1'b0)
        report_mismatch("flags_we", 64'd0, 64'(resp.flags_we));
    end
    rst = 1'b0;
    req = '0;
    end_test();

    begin_test("arith");
    repeat (80) begin
      r   = build_req(rand_below(2) ? op_sub : op_add, cc_z);
      r.a = pick_operand();
      r.b = pick_operand();
      send(r, 1'b0, 1'b0);
    end
    end_test();

    begin_test("bitwise");
    repeat (40) send(build_req(alu_op_e'(5'(2 + rand_below(4))), cc_z), 1'b0, 1'b0);
    end_test();

    begin_test("move_extend");
    repeat (40) send(build_req(alu_op_e'(5'(6 + rand_below(6))), cc_z), 1'b0, 1'b0);
    end_test();

    begin_test("conditional");
    for (int c = 0; c < 16; c++) begin
      repeat (4) begin
        send(build_req(op_cmov, 4'(c)), 1'b0, 1'b0);
        send(build_req(op_cset, 4'(c)), 1'b0, 1'b0);
      end
    end
    end_test();

    begin_test("flush");
    r        = build_req(op_mov, cc_z);
    r.thread = 1'b0;
    send(r, 1'b1, 1'b0);   // same edge
    send(r, 1'b0, 1'b0);   // next edge
    send(r, 1'b0, 1'b0);
    r.thread = 1'b1;
    send(r, 1'b1, 1'b0);   // other thread
    repeat (40) send(build_req(op_and, cc_z), rand_below(3) == 0, 1'(rand_below(2)));
    end_test();

    begin_test("stream");
    repeat (40) send(build_req(alu_op_e'(5'(rand_below(14))), 4'(rand_below(16))),
                     1'b0, 1'b0);
    end_test();

    $display("%0d tests passed, %0d tests failed", tests_passed, tests_failed);
    if (tests_failed == 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// ==== flist.f ====
verilog/alu_pkg.sv
verilog/cond_eval.sv
verilog/arith_unit.sv
verilog/logic_move_unit.sv
verilog/writeback_stage.sv
verilog/int_alu.sv
tb/int_alu_tb.sv

// ==== Bender.yml ====
package:
  name: int_alu

sources:
  # rtl
  - files:
      - verilog/alu_pkg.sv
      - verilog/cond_eval.sv
      - verilog/arith_unit.sv
      - verilog/logic_move_unit.sv
      - verilog/writeback_stage.sv
      - verilog/int_alu.sv
  # tb
  - target: test
    files:
      - tb/int_alu_tb.sv
